//--- Makefile
# Verilator build and run for the JTAG TAP network testbench

TOP = tapnw_tb
LOG = run.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f tapnw.f -Mdir obj_dir -o $(TOP)

# Exit status comes from the search of the log
run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/tapnw_tests.svh
/*
 * JTAG driving tasks and directed tests
 *   bit stepping, IR and DR scans, select writes
 *   reset state, select, IR chain, IDCODE, BYPASS and reset tests
 */

// One tck cycle, inputs set at this rising edge, tdo read at the next
task automatic jtag_step(input logic tms_v, input logic tdi_v, output logic tdo_v);
    tms <= tms_v;
    tdi <= tdi_v;
    @(negedge tck);
    tdo_en_mid = tdo_en;
    tap_en_mid = tap_en;
    @(posedge tck);
    tdo_v = tdo;
endtask

// Step outside any shift state, so tdo_en must stay low
task automatic walk(input logic tms_v);
    logic b;
    jtag_step(tms_v, 1'b0, b);
    check_flag("tdo_en", tdo_en_mid, 1'b0);
endtask

task automatic idle(input int cycles);
    repeat (cycles) walk(1'b0);
endtask

// rst_n low for 3 cycles, then on to Run-Test/Idle
task automatic reset_dut();
    @(posedge tck);
    rst_n <= 1'b0;
    tms   <= 1'b1;
    tdi   <= 1'b0;
    repeat (3) @(posedge tck);
    rst_n <= 1'b1;
    walk(1'b0);
    cur_en = '0;
endtask

function automatic int enabled_slaves();
    int n;
    n = 0;
    for (int i = 0; i < `TAPNW_NUM_STAPS; i++) begin
        if (cur_en[i]) n++;
    end
    return n;
endfunction

// IR image, master bits leave first, then slave 1, then slave 0
function automatic logic [127:0] ir_image(input logic [`MTAP_IR_WIDTH-1:0] m_op,
                                          input logic [`STAP_IR_WIDTH-1:0] s_op);
    logic [127:0] v;
    int           pos;
    v   = '0;
    v[`MTAP_IR_WIDTH-1:0] = m_op;
    pos = `MTAP_IR_WIDTH;
    for (int i = `TAPNW_NUM_STAPS - 1; i >= 0; i--) begin
        if (cur_en[i]) begin
            v[pos +: `STAP_IR_WIDTH] = s_op;
            pos += `STAP_IR_WIDTH;
        end
    end
    return v;
endfunction

// Run-Test/Idle to Run-Test/Idle, bit 0 of din shifted first
task automatic scan(input logic is_ir, input logic [127:0] din, input int len,
                    output logic [127:0] dout);
    logic b;
    dout = '0;
    walk(1'b1);
    if (is_ir) walk(1'b1);
    walk(1'b0);
    walk(1'b0);
    for (int i = 0; i < len; i++) begin
        jtag_step(i == len - 1, din[i], b);
        dout[i] = b;
        check_flag("tdo_en", tdo_en_mid, 1'b1);
    end
    // Update, then back to idle
    walk(1'b1);
    walk(1'b0);
endtask

// IR scan, each IR must capture ...01 at the head of tdo
task automatic scan_ir(input logic [127:0] din, input int len, output logic [127:0] dout);
    int pos;
    scan(1'b1, din, len, dout);
    check_ir_capture("tdo mtap ir capture", dout[7:0], 8'h01);
    pos = `MTAP_IR_WIDTH;
    for (int i = `TAPNW_NUM_STAPS - 1; i >= 0; i--) begin
        if (cur_en[i]) begin
            check_ir_capture("tdo stap ir capture", 8'(dout[pos +: `STAP_IR_WIDTH]), 8'h01);
            pos += `STAP_IR_WIDTH;
        end
    end
endtask

// Idle until tap_en applies exp_en
task automatic wait_tap_en(input tap_sel_t exp_en);
    int n;
    n = 0;
    walk(1'b0);
    while (tap_en_mid !== exp_en && n < 4) begin
        walk(1'b0);
        n++;
    end
    if (tap_en_mid !== exp_en) begin
        $display("tap_en did not change to %b within %0d cycles of idle", exp_en, n + 1);
        other_errs++;
    end
    cur_en = exp_en;
endtask

// SELECT write, readback shows the enables applied so far
task automatic write_select(input tap_sel_t new_sel);
    logic [127:0] dout;
    int           n;
    n = enabled_slaves();
    scan_ir(ir_image(`MTAP_OP_SELECT, `STAP_OP_BYPASS),
            `MTAP_IR_WIDTH + n * `STAP_IR_WIDTH, dout);
    scan(1'b0, 128'(new_sel), `TAPNW_NUM_STAPS + n, dout);
    check_sel("tdo select readback", dout[1:0], cur_en);
    wait_tap_en(new_sel);
endtask

task automatic test_reset_state();
    logic [127:0] dout;
    idle(2);
    check_sel("tap_en", tap_en_mid, '0);
    cur_en = '0;
    scan(1'b0, '0, `IDCODE_WIDTH, dout);
    check_idcode("tdo mtap idcode", dout[31:0], mtap_idcode);
endtask

task automatic test_select_writes();
    write_select(2'b01);
    write_select(2'b10);
    write_select(2'b11);
    write_select(2'b11);
endtask

task automatic test_ir_chain(input tap_sel_t sel);
    logic [127:0] din;
    logic [127:0] dout;
    int           len;
    int           n;
    int           pos;
    write_select(sel);
    n   = enabled_slaves();
    len = `MTAP_IR_WIDTH + n * `STAP_IR_WIDTH;
    // Random head flushed out, IDCODE image left in the IRs
    din = '0;
    for (int i = 0; i < len; i++) begin
        din[i] = rand_bit();
    end
    din = din | (ir_image(`MTAP_OP_IDCODE, `STAP_OP_IDCODE) << len);
    scan_ir(din, 2 * len, dout);
    for (int i = 0; i < len; i++) begin
        check_flag("tdo ir loopback", dout[len + i], din[i]);
    end
    scan(1'b0, '0, `IDCODE_WIDTH * (n + 1), dout);
    check_idcode("tdo mtap idcode", dout[31:0], mtap_idcode);
    pos = `IDCODE_WIDTH;
    if (sel[1]) begin
        check_idcode("tdo stap1 idcode", dout[pos +: `IDCODE_WIDTH], stap1_idcode);
        pos += `IDCODE_WIDTH;
    end
    if (sel[0]) check_idcode("tdo stap0 idcode", dout[pos +: `IDCODE_WIDTH], stap0_idcode);
endtask

// One-bit delay per TAP, captured zeros ahead of the data
task automatic test_bypass_chain();
    logic [127:0] din;
    logic [127:0] dout;
    int           taps;
    taps = enabled_slaves() + 1;
    scan_ir({128{1'b1}}, `MTAP_IR_WIDTH + (taps - 1) * `STAP_IR_WIDTH, dout);
    din = '0;
    for (int i = 0; i < 32; i++) begin
        din[i] = rand_bit();
    end
    scan(1'b0, din, 32 + taps, dout);
    for (int i = 0; i < taps; i++) begin
        check_flag("tdo bypass capture", dout[i], 1'b0);
    end
    for (int i = 0; i < 32; i++) begin
        check_flag("tdo bypass data", dout[taps + i], din[i]);
    end
endtask

// Leave a DR scan through five tms-high edges
task automatic test_tms_reset();
    logic b;
    walk(1'b1);
    walk(1'b0);
    walk(1'b0);
    repeat (4) jtag_step(1'b0, rand_bit(), b);
    repeat (5) jtag_step(1'b1, 1'b0, b);
    walk(1'b0);
    test_reset_state();
endtask

task automatic test_rst_mid_scan();
    logic b;
    write_select(2'b11);
    walk(1'b1);
    walk(1'b0);
    walk(1'b0);
    repeat (4) jtag_step(1'b0, rand_bit(), b);
    reset_dut();
    test_reset_state();
endtask

//--- dv/tapnw_tb.sv
/*
 * Testbench top for the JTAG TAP network
 *   clock, reset and DUT instance
 *   Galois LFSR for stimulus bits
 *   typed compare tasks and the closing report
 */
`timescale 1ns/1ns
`include "tapnw_consts.svh"

module tapnw_tb
    import tapnw_pkg::*;
();

    logic     tck;
    logic     rst_n;
    logic     tms;
    logic     tdi;
    idcode_t  mtap_idcode;
    idcode_t  stap0_idcode;
    idcode_t  stap1_idcode;
    logic     tdo;
    logic     tdo_en;
    tap_sel_t tap_en;

    // State-driven outputs, sampled at the falling edge
    logic        tdo_en_mid;
    tap_sel_t    tap_en_mid;
    // Enables the network should have applied
    tap_sel_t    cur_en;
    logic [15:0] lfsr;
    int          value_errs;
    int          other_errs;

    // 40 ns tck
    initial tck = 1'b0;
    always #20 tck = ~tck;

    tapnw_top i_dut (
        .tck          (tck),
        .rst_n        (rst_n),
        .tms          (tms),
        .tdi          (tdi),
        .mtap_idcode  (mtap_idcode),
        .stap0_idcode (stap0_idcode),
        .stap1_idcode (stap1_idcode),
        .tdo          (tdo),
        .tdo_en       (tdo_en),
        .tap_en       (tap_en)
    );

    // ------------------------------------------------------------------------
    // Stimulus bits
    // ------------------------------------------------------------------------
    // 16-bit Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    function automatic logic rand_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr_step(lfsr);
        return b;
    endfunction

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_idcode(input string name, input idcode_t got, input idcode_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_sel(input string name, input tap_sel_t got, input tap_sel_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_ir_capture(input string name,
                                    input logic [`MTAP_IR_WIDTH-1:0] got,
                                    input logic [`MTAP_IR_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            value_errs++;
        end
    endtask

    `include "tapnw_tests.svh"

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        rst_n        = 1'b0;
        tms          = 1'b1;
        tdi          = 1'b0;
        mtap_idcode  = 32'h4BA0_0477;
        stap0_idcode = 32'h1B2C_3D5F;
        stap1_idcode = 32'h0F0E_A1C3;
        lfsr         = 16'd78;
        cur_en       = '0;
        value_errs   = 0;
        other_errs   = 0;

        reset_dut();
        test_reset_state();
        test_select_writes();
        for (int s = 0; s < 4; s++) begin
            test_ir_chain(tap_sel_t'(s));
        end
        test_bypass_chain();
        test_tms_reset();
        test_rst_mid_scan();

        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- rtl/mtap.sv
/*
 * Master TAP on the primary JTAG port
 *   TAP controller and 8-bit IR
 *   IDCODE, BYPASS and network select data registers
 *   pending select output, falling-edge tdo and tdo_en
 */
`timescale 1ns/1ns
`include "tapnw_consts.svh"

module mtap
    import tapnw_pkg::*;
(
    input  logic       tck,
    input  logic       rst_n,
    input  logic       tms,
    input  logic       chain_tdo,
    input  idcode_t    idcode,
    input  tap_sel_t   tap_en,
    output tap_sel_t   tap_sel,
    output tap_state_t state,
    output logic       tdo,
    output logic       tdo_en
);

    logic [`MTAP_IR_WIDTH-1:0] ir;
    logic                      ir_so;
    mtap_op_t                  op;
    idcode_t                   idcode_sr;
    logic                      byp_sr;
    tap_sel_t                  sel_sr;
    logic                      dr_so;
    logic                      shift_so;

    tap_fsm i_fsm (
        .tck   (tck),
        .rst_n (rst_n),
        .tms   (tms),
        .state (state)
    );

    // Serial input is the tail of the slave chain
    tap_ir #(
        .IR_WIDTH (`MTAP_IR_WIDTH),
        .IR_RESET (MTAP_IDCODE)
    ) i_ir (
        .tck   (tck),
        .rst_n (rst_n),
        .state (state),
        .tdi   (chain_tdo),
        .ir    (ir),
        .so    (ir_so)
    );

    assign op = mtap_op_t'(ir);

    // ------------------------------------------------------------------------
    // Data registers
    // ------------------------------------------------------------------------
    always_ff @(posedge tck) begin
        if (state == ST_CAP_DR) begin
            case (op)
                MTAP_IDCODE: idcode_sr <= idcode;
                // Readback shows what the network has applied
                MTAP_SELECT: sel_sr    <= tap_en;
                default:     byp_sr    <= 1'b0;
            endcase
        end else if (state == ST_SHIFT_DR) begin
            case (op)
                MTAP_IDCODE: idcode_sr <= {chain_tdo, idcode_sr[`IDCODE_WIDTH-1:1]};
                MTAP_SELECT: sel_sr    <= {chain_tdo, sel_sr[`TAPNW_NUM_STAPS-1:1]};
                default:     byp_sr    <= chain_tdo;
            endcase
        end
    end

    // Pending select, applied later by the network in Run-Test/Idle
    always_ff @(posedge tck) begin
        if (!rst_n || state == ST_TLR) begin
            tap_sel <= '0;
        end else if (state == ST_UPD_DR && op == MTAP_SELECT) begin
            tap_sel <= sel_sr;
        end
    end

    // ------------------------------------------------------------------------
    // Serial output
    // ------------------------------------------------------------------------
    always_comb begin
        case (op)
            MTAP_IDCODE: dr_so = idcode_sr[0];
            MTAP_SELECT: dr_so = sel_sr[0];
            default:     dr_so = byp_sr;
        endcase
    end

    assign shift_so = (state == ST_SHIFT_IR) ? ir_so : dr_so;

    // Retimed half a cycle so the board samples it on the next rising edge
    always_ff @(negedge tck) begin
        if (!rst_n) begin
            tdo <= 1'b0;
        end else begin
            tdo <= shift_so;
        end
    end

    assign tdo_en = (state == ST_SHIFT_IR) || (state == ST_SHIFT_DR);

endmodule

//--- rtl/stap.sv
/*
 * Slave TAP
 *   TAP controller and 4-bit IR
 *   IDCODE and BYPASS data registers
 *   serial output straight from the active shift stage
 */
`timescale 1ns/1ns
`include "tapnw_consts.svh"

module stap
    import tapnw_pkg::*;
(
    input  logic    tck,
    input  logic    tap_rst_n,
    input  logic    tms,
    input  logic    tdi,
    input  idcode_t idcode,
    output logic    so
);

    tap_state_t                state;
    logic [`STAP_IR_WIDTH-1:0] ir;
    logic                      ir_so;
    stap_op_t                  op;
    logic                      sel_idcode;
    idcode_t                   idcode_sr;
    logic                      byp_sr;
    logic                      dr_so;

    // Held in TLR while the network keeps this slave disabled
    tap_fsm i_fsm (
        .tck   (tck),
        .rst_n (tap_rst_n),
        .tms   (tms),
        .state (state)
    );

    tap_ir #(
        .IR_WIDTH (`STAP_IR_WIDTH),
        .IR_RESET (STAP_IDCODE)
    ) i_ir (
        .tck   (tck),
        .rst_n (tap_rst_n),
        .state (state),
        .tdi   (tdi),
        .ir    (ir),
        .so    (ir_so)
    );

    // Anything but IDCODE falls back to BYPASS
    assign op         = stap_op_t'(ir);
    assign sel_idcode = (op == STAP_IDCODE);

    // ------------------------------------------------------------------------
    // Data registers
    // ------------------------------------------------------------------------
    always_ff @(posedge tck) begin
        if (state == ST_CAP_DR) begin
            if (sel_idcode) begin
                idcode_sr <= idcode;
            end else begin
                byp_sr <= 1'b0;
            end
        end else if (state == ST_SHIFT_DR) begin
            if (sel_idcode) begin
                idcode_sr <= {tdi, idcode_sr[`IDCODE_WIDTH-1:1]};
            end else begin
                byp_sr <= tdi;
            end
        end
    end

    assign dr_so = sel_idcode ? idcode_sr[0] : byp_sr;
    // IR path only while shifting the IR
    assign so    = (state == ST_SHIFT_IR) ? ir_so : dr_so;

endmodule

//--- rtl/tap_fsm.sv
/*
 * IEEE 1149.1 TAP controller
 *   16 states stepped by tms on the rising edge of tck
 *   synchronous reset into Test-Logic-Reset
 */
`timescale 1ns/1ns

module tap_fsm
    import tapnw_pkg::*;
(
    input  logic       tck,
    input  logic       rst_n,
    input  logic       tms,
    output tap_state_t state
);

    tap_state_t next_state;

    // ------------------------------------------------------------------------
    // Next state from tms
    // ------------------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            // Idle side
            ST_TLR:      next_state = tms ? ST_TLR    : ST_RTI;
            ST_RTI:      next_state = tms ? ST_SEL_DR : ST_RTI;
            // Data register column
            ST_SEL_DR:   next_state = tms ? ST_SEL_IR   : ST_CAP_DR;
            ST_CAP_DR:   next_state = tms ? ST_EXIT1_DR : ST_SHIFT_DR;
            ST_SHIFT_DR: next_state = tms ? ST_EXIT1_DR : ST_SHIFT_DR;
            ST_EXIT1_DR: next_state = tms ? ST_UPD_DR   : ST_PAUSE_DR;
            ST_PAUSE_DR: next_state = tms ? ST_EXIT2_DR : ST_PAUSE_DR;
            ST_EXIT2_DR: next_state = tms ? ST_UPD_DR   : ST_SHIFT_DR;
            ST_UPD_DR:   next_state = tms ? ST_SEL_DR   : ST_RTI;
            // Instruction register column
            ST_SEL_IR:   next_state = tms ? ST_TLR      : ST_CAP_IR;
            ST_CAP_IR:   next_state = tms ? ST_EXIT1_IR : ST_SHIFT_IR;
            ST_SHIFT_IR: next_state = tms ? ST_EXIT1_IR : ST_SHIFT_IR;
            ST_EXIT1_IR: next_state = tms ? ST_UPD_IR   : ST_PAUSE_IR;
            ST_PAUSE_IR: next_state = tms ? ST_EXIT2_IR : ST_PAUSE_IR;
            ST_EXIT2_IR: next_state = tms ? ST_UPD_IR   : ST_SHIFT_IR;
            ST_UPD_IR:   next_state = tms ? ST_SEL_DR   : ST_RTI;
            default:     next_state = ST_TLR;
        endcase
    end

    // ------------------------------------------------------------------------
    // State register
    // ------------------------------------------------------------------------
    always_ff @(posedge tck) begin
        if (!rst_n) begin
            state <= ST_TLR;
        end else begin
            state <= next_state;
        end
    end

endmodule

//--- rtl/tap_ir.sv
/*
 * Instruction register for a TAP
 *   capture of ...01, shift from tdi, update to ir
 *   ir returns to IR_RESET in Test-Logic-Reset
 */
`timescale 1ns/1ns
`include "tapnw_consts.svh"

module tap_ir #(
    parameter int                  IR_WIDTH = 4,
    parameter logic [IR_WIDTH-1:0] IR_RESET = '0
) (
    input  logic                tck,
    input  logic                rst_n,
    input  logic [3:0]          state,
    input  logic                tdi,
    output logic [IR_WIDTH-1:0] ir,
    output logic                so
);

    // Shift stage, bit 0 leaves first
    logic [IR_WIDTH-1:0] ir_sr;

    always_ff @(posedge tck) begin
        if (state == `TAP_ST_CAP_IR) begin
            ir_sr <= IR_WIDTH'(2'b01);
        end else if (state == `TAP_ST_SHIFT_IR) begin
            ir_sr <= {tdi, ir_sr[IR_WIDTH-1:1]};
        end
    end

    // Active instruction
    always_ff @(posedge tck) begin
        if (!rst_n || state == `TAP_ST_TLR) begin
            ir <= IR_RESET;
        end else if (state == `TAP_ST_UPD_IR) begin
            ir <= ir_sr;
        end
    end

    assign so = ir_sr[0];

endmodule

//--- rtl/tap_network.sv
/*
 * Slave TAP network
 *   applies the master's select in Run-Test/Idle
 *   per-slave reset from rst_n and the applied enable
 *   linear chain tdi -> slave 0 -> slave 1 -> chain_tdo
 */
`timescale 1ns/1ns
`include "tapnw_consts.svh"

module tap_network
    import tapnw_pkg::*;
(
    input  logic       tck,
    input  logic       rst_n,
    input  tap_state_t state,
    input  tap_sel_t   tap_sel,
    input  logic       tdi,
    input  tap_sel_t   stap_so,
    output tap_sel_t   tap_en,
    output tap_sel_t   stap_rst_n,
    output tap_sel_t   stap_tdi,
    output logic       chain_tdo
);

    // Point i feeds slave i, last point feeds the master
    logic [`TAPNW_NUM_STAPS:0] chain_pt;

    // Enables follow the pending select only while idling
    always_ff @(posedge tck) begin
        if (!rst_n || state == ST_TLR) begin
            tap_en <= '0;
        end else if (state == ST_RTI) begin
            tap_en <= tap_sel;
        end
    end

    // Disabled slave sits in TLR with its clock still running
    assign stap_rst_n = {`TAPNW_NUM_STAPS{rst_n}} & tap_en;

    // ------------------------------------------------------------------------
    // Chain, bypassing disabled slaves
    // ------------------------------------------------------------------------
    always_comb begin
        chain_pt[0] = tdi;
        for (int i = 0; i < `TAPNW_NUM_STAPS; i++) begin
            chain_pt[i+1] = tap_en[i] ? stap_so[i] : chain_pt[i];
        end
    end

    assign stap_tdi  = chain_pt[`TAPNW_NUM_STAPS-1:0];
    assign chain_tdo = chain_pt[`TAPNW_NUM_STAPS];

endmodule

//--- rtl/tapnw_consts.svh
/*
 * Shared constants for the JTAG TAP network
 *   slave count, register widths
 *   IEEE 1149.1 TAP state encodings
 *   master and slave opcode values
 */
`ifndef TAPNW_CONSTS_SVH
`define TAPNW_CONSTS_SVH

// Network size and register widths
`define TAPNW_NUM_STAPS   2
`define MTAP_IR_WIDTH     8
`define STAP_IR_WIDTH     4
`define IDCODE_WIDTH      32

// TAP state codes, standard 1149.1 encoding
`define TAP_ST_TLR        4'hF
`define TAP_ST_RTI        4'hC
`define TAP_ST_SEL_DR     4'h7
`define TAP_ST_CAP_DR     4'h6
`define TAP_ST_SHIFT_DR   4'h2
`define TAP_ST_EXIT1_DR   4'h1
`define TAP_ST_PAUSE_DR   4'h3
`define TAP_ST_EXIT2_DR   4'h0
`define TAP_ST_UPD_DR     4'h5
`define TAP_ST_SEL_IR     4'h4
`define TAP_ST_CAP_IR     4'hE
`define TAP_ST_SHIFT_IR   4'hA
`define TAP_ST_EXIT1_IR   4'h9
`define TAP_ST_PAUSE_IR   4'hB
`define TAP_ST_EXIT2_IR   4'h8
`define TAP_ST_UPD_IR     4'hD

// Opcodes
`define MTAP_OP_IDCODE    8'h02
`define MTAP_OP_SELECT    8'h11
`define MTAP_OP_BYPASS    8'hFF
`define STAP_OP_IDCODE    4'h2
`define STAP_OP_BYPASS    4'hF

`endif

//--- rtl/tapnw_pkg.sv
/*
 * Types for the JTAG TAP network
 *   tap_state_t  16-state TAP controller
 *   mtap_op_t    master instructions
 *   stap_op_t    slave instructions
 *   idcode_t, tap_sel_t
 */
`include "tapnw_consts.svh"

package tapnw_pkg;

    // TAP controller states, codes shared with tap_ir
    typedef enum logic [3:0] {
        ST_TLR      = `TAP_ST_TLR,
        ST_RTI      = `TAP_ST_RTI,
        ST_SEL_DR   = `TAP_ST_SEL_DR,
        ST_CAP_DR   = `TAP_ST_CAP_DR,
        ST_SHIFT_DR = `TAP_ST_SHIFT_DR,
        ST_EXIT1_DR = `TAP_ST_EXIT1_DR,
        ST_PAUSE_DR = `TAP_ST_PAUSE_DR,
        ST_EXIT2_DR = `TAP_ST_EXIT2_DR,
        ST_UPD_DR   = `TAP_ST_UPD_DR,
        ST_SEL_IR   = `TAP_ST_SEL_IR,
        ST_CAP_IR   = `TAP_ST_CAP_IR,
        ST_SHIFT_IR = `TAP_ST_SHIFT_IR,
        ST_EXIT1_IR = `TAP_ST_EXIT1_IR,
        ST_PAUSE_IR = `TAP_ST_PAUSE_IR,
        ST_EXIT2_IR = `TAP_ST_EXIT2_IR,
        ST_UPD_IR   = `TAP_ST_UPD_IR
    } tap_state_t;

    // Master instructions
    typedef enum logic [`MTAP_IR_WIDTH-1:0] {
        MTAP_IDCODE = `MTAP_OP_IDCODE,
        MTAP_SELECT = `MTAP_OP_SELECT,
        MTAP_BYPASS = `MTAP_OP_BYPASS
    } mtap_op_t;

    // Slave instructions
    typedef enum logic [`STAP_IR_WIDTH-1:0] {
        STAP_IDCODE = `STAP_OP_IDCODE,
        STAP_BYPASS = `STAP_OP_BYPASS
    } stap_op_t;

    typedef logic [`IDCODE_WIDTH-1:0]    idcode_t;
    // Bit i enables slave i
    typedef logic [`TAPNW_NUM_STAPS-1:0] tap_sel_t;

endpackage

//--- rtl/tapnw_top.sv
/*
 * TAP network top level
 *   master TAP, network and two slave TAPs
 */
`timescale 1ns/1ns

module tapnw_top
    import tapnw_pkg::*;
(
    input  logic     tck,
    input  logic     rst_n,
    input  logic     tms,
    input  logic     tdi,
    input  idcode_t  mtap_idcode,
    input  idcode_t  stap0_idcode,
    input  idcode_t  stap1_idcode,
    output logic     tdo,
    output logic     tdo_en,
    output tap_sel_t tap_en
);

    tap_sel_t   tap_sel;
    tap_state_t mtap_state;
    tap_sel_t   stap_rst_n;
    tap_sel_t   stap_tdi;
    tap_sel_t   stap_so;
    logic       chain_tdo;

    // Master sits last in the chain, ahead of tdo
    mtap i_mtap (
        .tck       (tck),
        .rst_n     (rst_n),
        .tms       (tms),
        .chain_tdo (chain_tdo),
        .idcode    (mtap_idcode),
        .tap_en    (tap_en),
        .tap_sel   (tap_sel),
        .state     (mtap_state),
        .tdo       (tdo),
        .tdo_en    (tdo_en)
    );

    tap_network i_tap_network (
        .tck        (tck),
        .rst_n      (rst_n),
        .state      (mtap_state),
        .tap_sel    (tap_sel),
        .tdi        (tdi),
        .stap_so    (stap_so),
        .tap_en     (tap_en),
        .stap_rst_n (stap_rst_n),
        .stap_tdi   (stap_tdi),
        .chain_tdo  (chain_tdo)
    );

    // Slave 0, first after tdi
    stap i_stap0 (
        .tck       (tck),
        .tap_rst_n (stap_rst_n[0]),
        .tms       (tms),
        .tdi       (stap_tdi[0]),
        .idcode    (stap0_idcode),
        .so        (stap_so[0])
    );

    stap i_stap1 (
        .tck       (tck),
        .tap_rst_n (stap_rst_n[1]),
        .tms       (tms),
        .tdi       (stap_tdi[1]),
        .idcode    (stap1_idcode),
        .so        (stap_so[1])
    );

endmodule

//--- tapnw.f
+incdir+rtl
+incdir+dv
rtl/tapnw_pkg.sv
rtl/tap_fsm.sv
rtl/tap_ir.sv
rtl/stap.sv
rtl/mtap.sv
rtl/tap_network.sv
rtl/tapnw_top.sv
dv/tapnw_tb.sv
